// ==== src/stream_pkg.sv ====
/* Shared stream types for the two-channel merge path. Widths are fixed here;
   the slice depth and channel count are compile-time constants. */

`default_nettype none

package stream_pkg;

    // Sample payload and tag widths
    localparam int DATA_WIDTH = 32;
    localparam int DEST_WIDTH = 8;
    localparam int USER_WIDTH = 16;

    // Number of front-end channels feeding the arbiter
    localparam int N_CHANNELS = 2;

    // Depth of the output register slice
    localparam int N_STAGES = 2;

    // One beat of the stream, tlast marks the final beat of a packet
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [DEST_WIDTH-1:0] dest;
        logic [USER_WIDTH-1:0] user;
        logic                  tlast;
    } stream_beat_t;

    // Arbiter grant state, one grant state per channel
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_CH0  = 2'd1,
        ARB_CH1  = 2'd2
    } arb_state_t;

endpackage

`default_nettype wire

// ==== src/sample_tagger.sv ====
/* Zero-latency tagger. dest and user of the incoming beat are overwritten;
   CHANNEL_ID must fit in DEST_WIDTH bits. */

`timescale 1ns/1ps
`default_nettype none

module sample_tagger #(
    parameter int unsigned CHANNEL_ID = 0
) (
    input  logic                     clock,
    input  logic                     reset,
    input  stream_pkg::stream_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output stream_pkg::stream_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);

    // Packet sequence number for this channel
    logic [stream_pkg::USER_WIDTH-1:0] seq_count;

    // Channel tag taken from the parameter
    logic [stream_pkg::DEST_WIDTH-1:0] channel_tag;

    // A beat moves downstream on this cycle
    logic transfer;

    // The final beat of a packet moves downstream on this cycle
    logic last_transfer;

    assign channel_tag = CHANNEL_ID[stream_pkg::DEST_WIDTH-1:0];

    // Handshake passes straight through, the tagger never stalls on its own
    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    assign transfer      = in_valid && out_ready;
    assign last_transfer = transfer && in_beat.tlast;

    // Data and tlast are untouched, the tag fields are replaced
    always_comb begin
        out_beat       = in_beat;
        out_beat.dest  = channel_tag;
        out_beat.user  = seq_count;
    end

    // The counter moves on the edge after a tlast transfer, so every beat
    // of one packet carries the same number. It wraps at the field width
    always_ff @(posedge clock) begin
        if (!reset) begin
            seq_count <= '0;
        end else if (last_transfer) begin
            seq_count <= seq_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/stream_arbiter.sv ====
/* Packet-locked round-robin arbiter for two streams. A grant is taken one cycle
   after a request is seen and held until the granted packet's tlast beat transfers. */

`timescale 1ns/1ps
`default_nettype none

module stream_arbiter (
    input  logic                     clock,
    input  logic                     reset,
    input  stream_pkg::stream_beat_t ch0_beat,
    input  logic                     ch0_valid,
    output logic                     ch0_ready,
    input  stream_pkg::stream_beat_t ch1_beat,
    input  logic                     ch1_valid,
    output logic                     ch1_ready,
    output stream_pkg::stream_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);

    stream_pkg::arb_state_t state;
    stream_pkg::arb_state_t state_next;

    // Channel that held the most recent grant, 1 means channel 1
    logic last_served;
    logic last_served_next;

    // End of the granted packet passes through on this cycle
    logic packet_done;

    // Output mux follows the current grant
    always_comb begin
        out_beat  = ch0_beat;
        out_valid = 1'b0;
        ch0_ready = 1'b0;
        ch1_ready = 1'b0;
        case (state)
            stream_pkg::ARB_CH0: begin
                out_beat  = ch0_beat;
                out_valid = ch0_valid;
                ch0_ready = out_ready;
            end
            stream_pkg::ARB_CH1: begin
                out_beat  = ch1_beat;
                out_valid = ch1_valid;
                ch1_ready = out_ready;
            end
            default: begin
                // Idle offers nothing and accepts nothing
                out_valid = 1'b0;
            end
        endcase
    end

    assign packet_done = out_valid && out_ready && out_beat.tlast;

    // Grant selection
    always_comb begin
        state_next       = state;
        last_served_next = last_served;
        case (state)
            stream_pkg::ARB_IDLE: begin
                if (ch0_valid && ch1_valid) begin
                    // Tie goes to the channel that was not served last
                    if (last_served) begin
                        state_next       = stream_pkg::ARB_CH0;
                        last_served_next = 1'b0;
                    end else begin
                        state_next       = stream_pkg::ARB_CH1;
                        last_served_next = 1'b1;
                    end
                end else if (ch0_valid) begin
                    state_next       = stream_pkg::ARB_CH0;
                    last_served_next = 1'b0;
                end else if (ch1_valid) begin
                    state_next       = stream_pkg::ARB_CH1;
                    last_served_next = 1'b1;
                end
            end
            stream_pkg::ARB_CH0, stream_pkg::ARB_CH1: begin
                if (packet_done) begin
                    state_next = stream_pkg::ARB_IDLE;
                end
            end
            default: begin
                state_next = stream_pkg::ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state       <= stream_pkg::ARB_IDLE;
            last_served <= 1'b1;
        end else begin
            state       <= state_next;
            last_served <= last_served_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/register_slice.sv ====
/* N_STAGES-deep pipeline with a combinational ready path. The whole chain
   advances only while out_ready is high, so bubbles are not squeezed out. */

`timescale 1ns/1ps
`default_nettype none

module register_slice (
    input  logic                     clock,
    input  logic                     reset,
    input  stream_pkg::stream_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output stream_pkg::stream_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);

    // Beat held in each stage, index 0 is the input side
    stream_pkg::stream_beat_t beat_q [stream_pkg::N_STAGES];

    // Occupancy of each stage
    logic [stream_pkg::N_STAGES-1:0] valid_q;

    // Upstream sees exactly the downstream ready
    assign in_ready = out_ready;

    // The last stage drives the output
    assign out_beat  = beat_q[stream_pkg::N_STAGES-1];
    assign out_valid = valid_q[stream_pkg::N_STAGES-1];

    // Payload shift chain
    always_ff @(posedge clock) begin
        if (out_ready) begin
            beat_q[0] <= in_beat;
            for (int i = 1; i < stream_pkg::N_STAGES; i++) begin
                beat_q[i] <= beat_q[i-1];
            end
        end
    end

    // Valid chain moves in lockstep with the payload
    always_ff @(posedge clock) begin
        if (!reset) begin
            valid_q <= '0;
        end else if (out_ready) begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < stream_pkg::N_STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/stream_merge_top.sv ====
/* Two tagged sample channels merged into one retimed stream. Input dest and
   user fields are ignored and replaced by the taggers. */

`timescale 1ns/1ps
`default_nettype none

module stream_merge_top (
    input  logic                     clock,
    input  logic                     reset,
    input  stream_pkg::stream_beat_t ch0_in,
    input  logic                     ch0_valid,
    output logic                     ch0_ready,
    input  stream_pkg::stream_beat_t ch1_in,
    input  logic                     ch1_valid,
    output logic                     ch1_ready,
    output stream_pkg::stream_beat_t out,
    output logic                     out_valid,
    input  logic                     out_ready
);

    // Tagger to arbiter links
    stream_pkg::stream_beat_t tag0_beat;
    logic                     tag0_valid;
    logic                     tag0_ready;
    stream_pkg::stream_beat_t tag1_beat;
    logic                     tag1_valid;
    logic                     tag1_ready;

    // Arbiter to slice link
    stream_pkg::stream_beat_t arb_beat;
    logic                     arb_valid;
    logic                     arb_ready;

    sample_tagger #(
        .CHANNEL_ID(0)
    ) u_tag0 (
        .clock    (clock),
        .reset    (reset),
        .in_beat  (ch0_in),
        .in_valid (ch0_valid),
        .in_ready (ch0_ready),
        .out_beat (tag0_beat),
        .out_valid(tag0_valid),
        .out_ready(tag0_ready)
    );

    sample_tagger #(
        .CHANNEL_ID(1)
    ) u_tag1 (
        .clock    (clock),
        .reset    (reset),
        .in_beat  (ch1_in),
        .in_valid (ch1_valid),
        .in_ready (ch1_ready),
        .out_beat (tag1_beat),
        .out_valid(tag1_valid),
        .out_ready(tag1_ready)
    );

    stream_arbiter u_arb (
        .clock    (clock),
        .reset    (reset),
        .ch0_beat (tag0_beat),
        .ch0_valid(tag0_valid),
        .ch0_ready(tag0_ready),
        .ch1_beat (tag1_beat),
        .ch1_valid(tag1_valid),
        .ch1_ready(tag1_ready),
        .out_beat (arb_beat),
        .out_valid(arb_valid),
        .out_ready(arb_ready)
    );

    register_slice u_slice (
        .clock    (clock),
        .reset    (reset),
        .in_beat  (arb_beat),
        .in_valid (arb_valid),
        .in_ready (arb_ready),
        .out_beat (out),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

`default_nettype wire

// ==== test/stream_asserts.sv ====
/* Handshake checks bound into stream_merge_top. The stall and grant checks
   are not evaluated while reset is asserted. */

`timescale 1ns/1ps
`default_nettype none

module stream_asserts (
    input logic                     clock,
    input logic                     reset,
    input logic                     ch0_valid,
    input logic                     ch0_ready,
    input logic                     ch1_valid,
    input logic                     ch1_ready,
    input stream_pkg::stream_beat_t out,
    input logic                     out_valid,
    input logic                     out_ready
);

    // The slice is empty one cycle after a reset edge
    valid_after_reset: assert property (@(posedge clock) !reset |=> !out_valid)
        else $error("out_valid high on the cycle after reset");

    // A stalled beat holds until the consumer takes it
    stalled_stable: assert property (@(posedge clock) disable iff (!reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out)))
        else $error("Stalled output beat changed or dropped valid");

    // Only the granted channel sees ready
    single_grant: assert property (@(posedge clock) disable iff (!reset)
        (ch0_valid && ch1_valid) |-> !(ch0_ready && ch1_ready))
        else $error("Both channels were ready at once");

endmodule

bind stream_merge_top stream_asserts u_asserts (
    .clock    (clock),
    .reset    (reset),
    .ch0_valid(ch0_valid),
    .ch0_ready(ch0_ready),
    .ch1_valid(ch1_valid),
    .ch1_ready(ch1_ready),
    .out      (out),
    .out_valid(out_valid),
    .out_ready(out_ready)
);

`default_nettype wire

// ==== test/tb_stream_merge.sv ====
/* Drives both channels from a table and checks the merged stream against a
   packet-level model. A channel holds valid high while it still has beats. */

`timescale 1ns/1ps
`default_nettype none

module tb_stream_merge;

    typedef struct packed {
        logic [1:0]                        mask;
        logic [stream_pkg::DATA_WIDTH-1:0] d0;
        logic                              l0;
        logic [stream_pkg::DATA_WIDTH-1:0] d1;
        logic                              l1;
    } row_t;

    localparam int N_ROWS  = 10;
    localparam int TIMEOUT = 2 * N_ROWS * 8 + 100;

    // Mask bit 0 offers on channel 0. Rows 0 and 1 hold a lone channel 0 packet
    row_t rows [N_ROWS] = '{
        '{2'b01, 32'hA000_0001, 1'b0, 32'h0000_0000, 1'b0},
        '{2'b01, 32'hA000_0002, 1'b1, 32'h0000_0000, 1'b0},
        '{2'b11, 32'hB000_0000, 1'b0, 32'hC000_0000, 1'b1},
        '{2'b11, 32'hB000_0001, 1'b1, 32'hC000_0001, 1'b0},
        '{2'b11, 32'hB000_0002, 1'b1, 32'hC000_0002, 1'b1},
        '{2'b10, 32'h0000_0000, 1'b0, 32'hC000_0003, 1'b1},
        '{2'b11, 32'hB000_0003, 1'b0, 32'hC000_0004, 1'b0},
        '{2'b11, 32'hB000_0004, 1'b0, 32'hC000_0005, 1'b1},
        '{2'b01, 32'hB000_0005, 1'b1, 32'h0000_0000, 1'b0},
        '{2'b11, 32'hB000_0006, 1'b1, 32'hC000_0006, 1'b1}
    };

    logic clock;
    logic reset;
    logic ch0_valid, ch1_valid, out_ready;
    logic ch0_ready, ch1_ready, out_valid;
    stream_pkg::stream_beat_t ch0_in, ch1_in, out;

    // Beats left to offer per channel, and the expected output order
    stream_pkg::stream_beat_t q0 [$];
    stream_pkg::stream_beat_t q1 [$];
    stream_pkg::stream_beat_t exp_q [$];
    logic [stream_pkg::USER_WIDTH-1:0] pkt_count [2];
    int idx0, idx1, last_ch, cycles, errors, seed, lat_in;
    logic fire0, fire1, stall_on, check_on, lat_check, lat_done;

    // Holds out_ready low so the slice keeps its beats across a reset
    logic freeze;

    stream_merge_top u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, want);
        end
    endtask

    task automatic check_beat(input stream_pkg::stream_beat_t got);
        stream_pkg::stream_beat_t want;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Output beat with data %h arrived after the expected stream ended",
                     got.data);
        end else begin
            want = exp_q.pop_front();
            compare_value("out.data", got.data, want.data);
            compare_value("out.dest", 32'(got.dest), 32'(want.dest));
            compare_value("out.user", 32'(got.user), 32'(want.user));
            compare_value("out.tlast", 32'(got.tlast), 32'(want.tlast));
        end
    endtask

    task automatic clear_model();
        pkt_count[0] = '0;
        pkt_count[1] = '0;
        last_ch      = 1;
    endtask

    // Loads rows into the channel lists, predicts the output and waits for it
    task automatic run_phase(input int first, input int last, input logic stall,
                             input logic check);
        stream_pkg::stream_beat_t b;
        int p0;
        int p1;
        int ch;
        check_on = check;
        q0.delete();
        q1.delete();
        for (int r = first; r <= last; r++) begin
            b       = '0;
            b.data  = rows[r].d0;
            b.tlast = rows[r].l0;
            if (rows[r].mask[0]) q0.push_back(b);
            b.data  = rows[r].d1;
            b.tlast = rows[r].l1;
            if (rows[r].mask[1]) q1.push_back(b);
        end
        p0 = 0;
        p1 = 0;
        // Whole packets in round robin, the idle channel loses no turn
        while (check && (p0 < q0.size() || p1 < q1.size())) begin
            if (p0 < q0.size() && p1 < q1.size()) ch = 1 - last_ch;
            else ch = (p0 < q0.size()) ? 0 : 1;
            do begin
                if (ch == 0) begin
                    b = q0[p0];
                    p0++;
                end else begin
                    b = q1[p1];
                    p1++;
                end
                b.dest = ch[stream_pkg::DEST_WIDTH-1:0];
                b.user = pkt_count[ch];
                exp_q.push_back(b);
            end while (!b.tlast);
            pkt_count[ch] = pkt_count[ch] + 1'b1;
            last_ch       = ch;
        end
        idx0     = 0;
        idx1     = 0;
        stall_on = stall;
        while (exp_q.size() != 0) @(negedge clock);
    endtask

    // Each channel presents its next beat right after a transfer
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (fire0) idx0 = idx0 + 1;
        if (fire1) idx1 = idx1 + 1;
        ch0_valid <= idx0 < q0.size();
        ch1_valid <= idx1 < q1.size();
        if (idx0 < q0.size()) ch0_in <= q0[idx0];
        if (idx1 < q1.size()) ch1_in <= q1[idx1];
        out_ready <= !freeze && (!stall_on || (($random(seed) & 3) != 0));
    end

    // Handshakes are sampled at the falling edge where every signal is settled
    always @(negedge clock) begin
        fire0 = ch0_valid && ch0_ready;
        fire1 = ch1_valid && ch1_ready;
        if (lat_check && fire0 && lat_in < 0) lat_in = cycles;
        if (reset && check_on && out_valid && out_ready) begin
            if (lat_check && !lat_done) begin
                lat_done = 1'b1;
                compare_value("latency", cycles - lat_in, stream_pkg::N_STAGES);
            end
            check_beat(out);
        end
    end

    always @(posedge clock) begin
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles with %0d beats still expected",
                     cycles, exp_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        reset     <= 1'b0;
        ch0_in    <= '0;
        ch1_in    <= '0;
        ch0_valid <= 1'b0;
        ch1_valid <= 1'b0;
        out_ready <= 1'b0;
        cycles    <= 0;
        fire0     = 1'b0;
        fire1     = 1'b0;
        stall_on  = 1'b0;
        check_on  = 1'b0;
        lat_check = 1'b0;
        lat_done  = 1'b0;
        freeze    = 1'b0;
        idx0      = 0;
        idx1      = 0;
        errors    = 0;
        seed   = 58077;
        lat_in = -1;
        clear_model();
        repeat (16) @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        lat_check = 1'b1;
        run_phase(0, 1, 1'b0, 1'b1);
        lat_check = 1'b0;
        if (!lat_done) begin
            errors++;
            $display("The first packet never reached the output for its latency check");
        end
        run_phase(2, 9, 1'b1, 1'b1);
        // Traffic that reset cuts off in the middle of a packet
        run_phase(2, 9, 1'b0, 1'b0);
        repeat (6) @(negedge clock);
        // The slice stops with a valid beat at its output before reset hits it
        freeze = 1'b1;
        q0.delete();
        q1.delete();
        @(posedge clock);
        reset <= 1'b0;
        repeat (3) @(negedge clock);
        if (out_valid !== 1'b0) begin
            errors++;
            $display("out_valid stayed high while reset was asserted");
        end
        freeze = 1'b0;
        @(posedge clock);
        reset <= 1'b1;
        clear_model();
        @(negedge clock);
        run_phase(2, 9, 1'b1, 1'b1);
        repeat (8) @(negedge clock);
        $display("Errors: %0d, unmatched beats: %0d", errors, exp_q.size());
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
src/stream_pkg.sv
src/sample_tagger.sv
src/stream_arbiter.sv
src/register_slice.sv
src/stream_merge_top.sv
test/stream_asserts.sv
test/tb_stream_merge.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_stream_merge -f sources.f -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
